// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    //////////////////////////////
    // Widths and geometry
    //////////////////////////////

    localparam int XLEN        = 32;           // Data and address width
    localparam logic [XLEN-1:0] RESET_PC = '0; // First fetch address

    localparam int BTB_ENTRIES = 32;
    localparam int BTB_INDEX_W = 5;            // Index taken from PC[6:2]

    localparam int IMEM_WORDS  = 64;           // ROM depth
    localparam int IMEM_ADDR_W = 6;            // Word address, PC[7:2]
    localparam string IMEM_INIT_FILE = "program.hex";

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    //////////////////////////////
    // Enums
    //////////////////////////////

    // Upper bit set means predict taken
    typedef enum logic [1:0] {
        STRONGLY_UNTAKEN = 2'b00,
        WEAKLY_UNTAKEN   = 2'b01,
        WEAKLY_TAKEN     = 2'b10,
        STRONGLY_TAKEN   = 2'b11
    } bp_state_e;

    // RV32I major opcodes seen by fetch
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_OP_IMM = 7'b0010011
    } opcode_e;

endpackage

// ==== src/branch_predictor.sv ====
module branch_predictor (
    input  logic CLK,
    input  logic RST,
    input  logic branch_e,      // Resolved branch in execute
    input  logic taken_e,       // Its real outcome
    output logic predict_taken
);
    import fetch_pkg::*;

    bp_state_e state_q;
    bp_state_e state_d;

    //////////////////////////////
    // Saturating counter
    //////////////////////////////

    always_ff @(posedge CLK) begin
        if (RST) begin
            state_q <= WEAKLY_TAKEN; // Lean taken out of reset
        end else begin
            state_q <= state_d;
        end
    end

    // One step per resolved branch, toward the outcome
    always_comb begin
        state_d = state_q;
        if (branch_e) begin
            case (state_q)
                STRONGLY_UNTAKEN: state_d = taken_e ? WEAKLY_UNTAKEN : STRONGLY_UNTAKEN;
                WEAKLY_UNTAKEN:   state_d = taken_e ? WEAKLY_TAKEN   : STRONGLY_UNTAKEN;
                WEAKLY_TAKEN:     state_d = taken_e ? STRONGLY_TAKEN : WEAKLY_UNTAKEN;
                STRONGLY_TAKEN:   state_d = taken_e ? STRONGLY_TAKEN : WEAKLY_TAKEN;
                default:          state_d = WEAKLY_TAKEN; // Recover from a bad encoding
            endcase
        end
    end

    assign predict_taken = state_q[1]; // MSB is the taken half

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Counter must always hold a defined state once out of reset
    a_state_known: assert property (
        @(posedge CLK) disable iff (RST)
        !$isunknown(state_q)
    ) else $error("branch_predictor: state unknown");

endmodule

// ==== src/branch_target_buffer.sv ====
module branch_target_buffer (
    input  logic                       CLK,
    input  logic                       RST,
    input  logic [fetch_pkg::XLEN-1:0] lookup_pc,    // Fetch PC
    input  logic                       write_en,     // Taken branch resolved
    input  logic [fetch_pkg::XLEN-1:0] write_pc,     // PC of that branch
    input  logic [fetch_pkg::XLEN-1:0] write_target, // Where it went
    output logic                       hit,
    output logic [fetch_pkg::XLEN-1:0] hit_target
);
    import fetch_pkg::*;

    // Direct-mapped storage, full PC kept as the tag
    logic [XLEN-1:0] tag_mem    [BTB_ENTRIES];
    logic [XLEN-1:0] target_mem [BTB_ENTRIES];
    logic            valid_q    [BTB_ENTRIES];

    logic [BTB_INDEX_W-1:0] rd_idx;
    logic [BTB_INDEX_W-1:0] wr_idx;

    // Skip the two byte-offset bits
    assign rd_idx = lookup_pc[BTB_INDEX_W+1:2];
    assign wr_idx = write_pc[BTB_INDEX_W+1:2];

    //////////////////////////////
    // Write side
    //////////////////////////////

    // Valid bits are the only state reset touches
    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (write_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (write_en) begin
            tag_mem[wr_idx]    <= write_pc;
            target_mem[wr_idx] <= write_target; // Last taken target wins
        end
    end

    //////////////////////////////
    // Lookup
    //////////////////////////////

    // Asynchronous read so the prediction lands in the same fetch cycle
    always_comb begin
        hit        = valid_q[rd_idx] && (tag_mem[rd_idx] == lookup_pc);
        hit_target = '0;
        if (hit) begin
            hit_target = target_mem[rd_idx];
        end
    end

    // The entry just written answers a lookup of its own PC
    a_write_then_hit: assert property (
        @(posedge CLK) disable iff (RST)
        write_en |=> (lookup_pc != $past(write_pc)) || hit
    ) else $error("branch_target_buffer: miss on a freshly written pc");

endmodule

// ==== src/fetch_stage.sv ====
module fetch_stage (
    input  logic                       CLK,
    input  logic                       RST,
    input  logic                       stall,           // From hazard unit
    input  logic                       branch_e,        // Branch resolved in execute
    input  logic                       taken_e,
    input  logic                       predicted_e,     // Prediction it carried
    input  logic [fetch_pkg::XLEN-1:0] pc_e,
    input  logic [fetch_pkg::XLEN-1:0] pc_plus_4_e,
    input  logic [fetch_pkg::XLEN-1:0] target_e,
    output logic [fetch_pkg::XLEN-1:0] pc_f,
    output logic [fetch_pkg::XLEN-1:0] pc_plus_4_f,
    output logic                       predict_taken_f,
    output logic                       btb_hit_f,
    output logic                       redirect         // Wrong path, squash
);
    import fetch_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] btb_target;
    logic            bp_taken;
    logic            btb_hit;
    logic            btb_write;
    logic            redirect_taken;
    logic            redirect_fallthrough;

    //////////////////////////////
    // Predictor and BTB
    //////////////////////////////

    branch_predictor u_bp (
        .CLK          (CLK),
        .RST          (RST),
        .branch_e     (branch_e),
        .taken_e      (taken_e),
        .predict_taken(bp_taken)
    );

    assign btb_write = branch_e && taken_e; // Only taken branches are recorded

    branch_target_buffer u_btb (
        .CLK         (CLK),
        .RST         (RST),
        .lookup_pc   (pc_q),
        .write_en    (btb_write),
        .write_pc    (pc_e),
        .write_target(target_e),
        .hit         (btb_hit),
        .hit_target  (btb_target)
    );

    // No target, no taken prediction
    assign predict_taken_f = bp_taken && btb_hit;
    assign btb_hit_f       = btb_hit;

    //////////////////////////////
    // Mispredict detection
    //////////////////////////////

    // Went taken but fetch ran on sequentially
    assign redirect_taken       = branch_e && taken_e && !predicted_e;
    // Fetch jumped to the target but branch fell through
    assign redirect_fallthrough = branch_e && !taken_e && predicted_e;
    assign redirect             = redirect_taken || redirect_fallthrough;

    //////////////////////////////
    // Next PC and PC register
    //////////////////////////////

    assign pc_plus_4_f = pc_q + XLEN'(4);

    // Priority: corrections, then stall, then prediction
    always_comb begin
        if (redirect_taken) begin
            pc_next = target_e;
        end else if (redirect_fallthrough) begin
            pc_next = pc_plus_4_e;
        end else if (stall) begin
            pc_next = pc_q;           // Hold
        end else if (predict_taken_f) begin
            pc_next = btb_target;
        end else begin
            pc_next = pc_plus_4_f;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= {pc_next[XLEN-1:2], 2'b00}; // Word align every load
        end
    end

    assign pc_f = pc_q;

    // Fall-through correction resumes at the word after the branch
    a_fallthrough_pc: assert property (
        @(posedge CLK) disable iff (RST)
        redirect_fallthrough |=> pc_f == {$past(pc_e[XLEN-1:2]) + (XLEN-2)'(1), 2'b00}
    ) else $error("fetch_stage: fall-through correction went to %h", pc_f);

endmodule

// ==== src/instr_mem.sv ====
module instr_mem (
    input  logic [fetch_pkg::XLEN-1:0] addr,  // Byte address from fetch
    output logic [fetch_pkg::XLEN-1:0] instr
);
    import fetch_pkg::*;

    logic [XLEN-1:0] rom [IMEM_WORDS];

    logic [IMEM_ADDR_W-1:0] word_addr;
    logic                   in_range;

    // ROM image and sanity check on the first word
    initial begin
        opcode_e first_op;
        $readmemh(IMEM_INIT_FILE, rom);
        first_op = opcode_e'(rom[0][6:0]);
        if (first_op.name() == "") begin
            $error("instr_mem: word 0 opcode %b not a known opcode", rom[0][6:0]);
        end
    end

    assign word_addr = addr[IMEM_ADDR_W+1:2];           // Drop byte offset
    assign in_range  = addr[XLEN-1:2] < IMEM_WORDS;

    // Past the end reads as a NOP
    assign instr = in_range ? rom[word_addr] : NOP_INSTR;

endmodule

// ==== src/if_id_reg.sv ====
module if_id_reg (
    input  logic                       CLK,
    input  logic                       RST,
    input  logic                       stall,
    input  logic                       redirect,        // Squash the wrong-path fetch
    input  logic [fetch_pkg::XLEN-1:0] pc_f,
    input  logic [fetch_pkg::XLEN-1:0] pc_plus_4_f,
    input  logic [fetch_pkg::XLEN-1:0] instr_f,
    input  logic                       predict_taken_f,
    input  logic                       btb_hit_f,
    output logic [fetch_pkg::XLEN-1:0] pc_d,
    output logic [fetch_pkg::XLEN-1:0] pc_plus_4_d,
    output logic [fetch_pkg::XLEN-1:0] instr_d,
    output logic                       predict_taken_d,
    output logic                       btb_hit_d,
    output logic                       valid_d
);
    import fetch_pkg::*;

    //////////////////////////////
    // Control bits
    //////////////////////////////

    always_ff @(posedge CLK) begin
        if (RST) begin
            valid_d         <= 1'b0;
            predict_taken_d <= 1'b0;
            btb_hit_d       <= 1'b0;
        end else if (redirect) begin  // Bubble, beats stall
            valid_d         <= 1'b0;
            predict_taken_d <= 1'b0;
            btb_hit_d       <= 1'b0;
        end else if (!stall) begin
            valid_d         <= 1'b1;
            predict_taken_d <= predict_taken_f;
            btb_hit_d       <= btb_hit_f;
        end
    end

    // Payload
    always_ff @(posedge CLK) begin
        if (redirect || !stall) begin
            pc_d        <= pc_f;
            pc_plus_4_d <= pc_plus_4_f;
            instr_d     <= redirect ? NOP_INSTR : instr_f; // NOP in the bubble
        end
    end

    // A taken prediction always travels with the BTB hit that gave its target
    a_pred_has_hit: assert property (
        @(posedge CLK) disable iff (RST)
        predict_taken_d |-> btb_hit_d
    ) else $error("if_id_reg: predict_taken_d without btb_hit_d");

endmodule

// ==== src/fetch_top.sv ====
module fetch_top (
    input  logic                       CLK,
    input  logic                       RST,
    input  logic                       stall,
    input  logic                       branch_e,
    input  logic                       taken_e,
    input  logic                       predicted_e,
    input  logic [fetch_pkg::XLEN-1:0] pc_e,
    input  logic [fetch_pkg::XLEN-1:0] pc_plus_4_e,
    input  logic [fetch_pkg::XLEN-1:0] target_e,
    output logic [fetch_pkg::XLEN-1:0] pc_f,
    output logic [fetch_pkg::XLEN-1:0] pc_d,
    output logic [fetch_pkg::XLEN-1:0] pc_plus_4_d,
    output logic [fetch_pkg::XLEN-1:0] instr_d,
    output logic                       predict_taken_d,
    output logic                       btb_hit_d,
    output logic                       valid_d
);
    import fetch_pkg::*;

    logic [XLEN-1:0] pc_plus_4_f;
    logic [XLEN-1:0] instr_f;
    logic            predict_taken_f;
    logic            btb_hit_f;
    logic            redirect;

    //////////////////////////////
    // Fetch, ROM, IF/ID
    //////////////////////////////

    fetch_stage u_fetch (
        .CLK            (CLK),
        .RST            (RST),
        .stall          (stall),
        .branch_e       (branch_e),
        .taken_e        (taken_e),
        .predicted_e    (predicted_e),
        .pc_e           (pc_e),
        .pc_plus_4_e    (pc_plus_4_e),
        .target_e       (target_e),
        .pc_f           (pc_f),
        .pc_plus_4_f    (pc_plus_4_f),
        .predict_taken_f(predict_taken_f),
        .btb_hit_f      (btb_hit_f),
        .redirect       (redirect)
    );

    // Same-cycle instruction for pc_f
    instr_mem u_imem (
        .addr (pc_f),
        .instr(instr_f)
    );

    if_id_reg u_if_id (
        .CLK            (CLK),
        .RST            (RST),
        .stall          (stall),
        .redirect       (redirect),
        .pc_f           (pc_f),
        .pc_plus_4_f    (pc_plus_4_f),
        .instr_f        (instr_f),
        .predict_taken_f(predict_taken_f),
        .btb_hit_f      (btb_hit_f),
        .pc_d           (pc_d),
        .pc_plus_4_d    (pc_plus_4_d),
        .instr_d        (instr_d),
        .predict_taken_d(predict_taken_d),
        .btb_hit_d      (btb_hit_d),
        .valid_d        (valid_d)
    );

endmodule

// ==== test/tb_fetch_top.sv ====
module tb_fetch_top;
    timeunit 1ns;
    timeprecision 100ps;

    import fetch_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 3;
    // Sequential, stall, redirect, learn, unlearn, stall with redirect
    localparam int TEST_CYCLES   = 13 + 9 + 19 + 11 + 14 + 10;
    localparam int MARGIN_CYCLES = 40;
    localparam int TIMEOUT_NS    = (RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;
    localparam logic [XLEN-1:0] IMAGE_BYTES = 32'h40;  // 16 words in the hex image

    logic            CLK, RST, stall;
    logic            branch_e, taken_e, predicted_e;   // Execute stage view
    logic [XLEN-1:0] pc_e, pc_plus_4_e, target_e;
    logic [XLEN-1:0] pc_f, pc_d, pc_plus_4_d, instr_d;
    logic            predict_taken_d, btb_hit_d, valid_d;

    //////////////////////////////
    // Reference model state
    //////////////////////////////

    logic [XLEN-1:0]        m_pc;                      // Expected fetch PC
    logic [1:0]             m_cnt;                     // 2-bit counter, MSB is taken
    logic [BTB_ENTRIES-1:0] m_btb_valid;
    logic [XLEN-1:0]        m_btb_tag [BTB_ENTRIES];
    logic [XLEN-1:0]        m_btb_tgt [BTB_ENTRIES];
    logic [XLEN-1:0]        m_rom [IMEM_WORDS];
    logic [XLEN-1:0]        m_pc_d, m_instr_d;         // Expected decode payload
    logic                   m_valid_d, m_pt_d, m_hit_d;
    logic                   mispredict;

    string  cur_test = "reset";
    string  first_msg;
    int     test_errs  = 0;
    int     total_errs = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    integer seed = 34708;

    fetch_top dut (.*);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // Prediction was wrong in either direction
    assign mispredict = branch_e && (taken_e != predicted_e);

    function automatic logic [XLEN-1:0] rom_word(input logic [XLEN-1:0] addr);
        if (addr[XLEN-1:2] < 30'(IMEM_WORDS)) begin
            return m_rom[addr[7:2]];
        end
        return NOP_INSTR;                              // Beyond the ROM
    endfunction

    function automatic void log_failure(input string msg);
        $display("%s", msg);
        if (test_errs == 0) begin
            first_msg = msg;                           // Kept for the test summary
        end
        test_errs++;
        total_errs++;
    endfunction

    function automatic void note_mismatch(input string sig, input logic [XLEN-1:0] exp,
                                          input logic [XLEN-1:0] act);
        log_failure($sformatf("Fail %s expected %h actual %h on %s", cur_test, exp, act, sig));
    endfunction

    function automatic void note_failure(input string what);
        log_failure($sformatf("Test %s: %s", cur_test, what));
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    always @(posedge CLK) begin : ref_model
        logic [BTB_INDEX_W-1:0] idx;
        logic                   hit;
        logic                   pred;
        logic [XLEN-1:0]        nxt;
        idx  = m_pc[6:2];
        hit  = m_btb_valid[idx] && (m_btb_tag[idx] == m_pc);
        pred = hit && m_cnt[1];                        // Needs a target and a taken counter
        if (RST) begin
            m_pc        <= RESET_PC;
            m_cnt       <= 2'b10;                      // Weakly taken
            m_btb_valid <= '0;
            m_valid_d   <= 1'b0;
            m_pt_d      <= 1'b0;
            m_hit_d     <= 1'b0;
        end else begin
            // Next PC, highest priority first
            if (branch_e && taken_e && !predicted_e) begin
                nxt = target_e;
            end else if (branch_e && !taken_e && predicted_e) begin
                nxt = pc_plus_4_e;
            end else if (stall) begin
                nxt = m_pc;
            end else if (pred) begin
                nxt = m_btb_tgt[idx];
            end else begin
                nxt = m_pc + 32'd4;
            end
            m_pc <= {nxt[XLEN-1:2], 2'b00};
            if (mispredict) begin                      // Bubble beats stall
                m_valid_d <= 1'b0;
                m_pt_d    <= 1'b0;
                m_hit_d   <= 1'b0;
            end else if (!stall) begin
                m_valid_d <= 1'b1;
                m_pt_d    <= pred;
                m_hit_d   <= hit;
                m_pc_d    <= m_pc;
                m_instr_d <= rom_word(m_pc);
            end
            if (branch_e && taken_e) begin
                if (m_cnt != 2'b11) m_cnt <= m_cnt + 2'd1;
                m_btb_valid[pc_e[6:2]] <= 1'b1;
                m_btb_tag[pc_e[6:2]]   <= pc_e;
                m_btb_tgt[pc_e[6:2]]   <= target_e;
            end else if (branch_e && m_cnt != 2'b00) begin
                m_cnt <= m_cnt - 2'd1;                 // Not taken, step down
            end
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_pc: assert property (@(posedge CLK) disable iff (RST) pc_f == m_pc)
        else note_mismatch("pc_f", $sampled(m_pc), $sampled(pc_f));
    a_valid: assert property (@(posedge CLK) disable iff (RST) valid_d == m_valid_d)
        else note_mismatch("valid_d", $sampled(m_valid_d), $sampled(valid_d));
    a_pc_d: assert property (@(posedge CLK) disable iff (RST)
        m_valid_d |-> (pc_d == m_pc_d) && (pc_plus_4_d == m_pc_d + 32'd4))
        else note_mismatch("pc_d", $sampled(m_pc_d), $sampled(pc_d));
    // Only words that the hex image defines
    a_instr: assert property (@(posedge CLK) disable iff (RST)
        (m_valid_d && m_pc_d < IMAGE_BYTES) |-> instr_d == m_instr_d)
        else note_mismatch("instr_d", $sampled(m_instr_d), $sampled(instr_d));
    a_pred: assert property (@(posedge CLK) disable iff (RST) predict_taken_d == m_pt_d)
        else note_mismatch("predict_taken_d", $sampled(m_pt_d), $sampled(predict_taken_d));
    a_hit: assert property (@(posedge CLK) disable iff (RST) btb_hit_d == m_hit_d)
        else note_mismatch("btb_hit_d", $sampled(m_hit_d), $sampled(btb_hit_d));
    a_hold: assert property (@(posedge CLK) disable iff (RST)
        (stall && !mispredict) |=> $stable(pc_f) && $stable(pc_d) && $stable(instr_d)
            && $stable(valid_d) && $stable(predict_taken_d) && $stable(btb_hit_d))
        else note_failure("fetch or decode outputs moved while stalled");
    // Corrected PC and a NOP bubble one cycle after any mispredict
    a_redirect: assert property (@(posedge CLK) disable iff (RST)
        mispredict |=> !valid_d && (instr_d == NOP_INSTR)
            && (pc_f == (($past(taken_e) ? $past(target_e) : $past(pc_plus_4_e)) & ~32'h3)))
        else note_failure("mispredict did not redirect fetch with a bubble");

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic next_cycles(input int n);
        repeat (n) begin
            @(posedge CLK);
            #0.5;                                      // Drive just after the edge
        end
    endtask

    // One resolved branch, present for a single cycle
    task automatic resolve_branch(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tgt,
                                  input logic taken, input logic pred);
        branch_e    = 1'b1;
        taken_e     = taken;
        predicted_e = pred;
        pc_e        = pc;
        pc_plus_4_e = pc + 32'd4;
        target_e    = tgt;
        next_cycles(1);
        branch_e    = 1'b0;
        taken_e     = 1'b0;
        predicted_e = 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        next_cycles(1);                                // Last one-cycle checks land here
        if (test_errs == 0) begin
            $display("Pass %s", cur_test);
            pass_count++;
        end else begin
            $display("%s (%0d errors)", first_msg, test_errs);
            fail_count++;
        end
    endtask

    initial begin
        CLK         = 1'b0;
        RST         = 1'b1;
        stall       = 1'b0;
        branch_e    = 1'b0;
        taken_e     = 1'b0;
        predicted_e = 1'b0;
        pc_e        = '0;
        pc_plus_4_e = '0;
        target_e    = '0;
        $readmemh("test/program.hex", m_rom);
        repeat (RESET_CYCLES) @(posedge CLK);
        #0.5;
        RST = 1'b0;

        start_test("sequential_fetch");
        next_cycles(12);
        finish_test();

        start_test("stall_hold");
        stall = 1'b1;
        next_cycles(4);
        stall = 1'b0;
        next_cycles(4);
        finish_test();

        // Misaligned random targets, branch PCs away from the fetch range
        start_test("unpredicted_taken");
        for (int k = 0; k < 3; k++) begin
            resolve_branch(32'h400 + 32'(k) * 4, ($random(seed) & 32'h3F) | 32'h1, 1'b1, 1'b0);
            next_cycles(2);
        end
        for (int k = 0; k < 3; k++) begin
            resolve_branch(32'h440 + 32'(k) * 4, $random(seed) & 32'h3F,
                           1'($random(seed)), 1'($random(seed)));
            next_cycles(2);
        end
        finish_test();

        start_test("learned_prediction");
        resolve_branch(32'h08, 32'h20, 1'b1, 1'b0);    // Record 0x08 -> 0x20
        next_cycles(2);
        resolve_branch(32'h400, 32'h00, 1'b1, 1'b0);   // Back to the start
        next_cycles(6);                                // 0, 4, 8, then the stored target
        finish_test();

        start_test("wrong_prediction");
        resolve_branch(32'h08, 32'h20, 1'b0, 1'b1);    // Predicted taken, fell through
        next_cycles(2);
        resolve_branch(32'h08, 32'h20, 1'b0, 1'b1);
        resolve_branch(32'h08, 32'h20, 1'b0, 1'b1);
        next_cycles(1);
        resolve_branch(32'h400, 32'h00, 1'b1, 1'b0);
        next_cycles(6);                                // Hit at 0x08, no taken prediction
        finish_test();

        start_test("redirect_in_stall");
        stall = 1'b1;
        next_cycles(2);
        resolve_branch(32'h404, 32'h16, 1'b1, 1'b0);   // Redirect beats the stall
        next_cycles(2);
        stall = 1'b0;
        next_cycles(4);
        finish_test();

        $display("Tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && total_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: run still going after %0d ns", TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
src/fetch_pkg.sv
src/branch_predictor.sv
src/branch_target_buffer.sv
src/fetch_stage.sv
src/instr_mem.sv
src/if_id_reg.sv
src/fetch_top.sv
test/tb_fetch_top.sv

// ==== Makefile ====
# Verilator flow for the fetch subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
ROM_IMAGE ?= test/program.hex
ROM_NAME  ?= program.hex
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TB PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory and the copied ROM image"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR ROM_IMAGE ROM_NAME VFLAGS"

# The ROM opens its image by bare file name in the run directory
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	cp $(ROM_IMAGE) $(ROM_NAME)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR) $(ROM_NAME)

// ==== test/program.hex ====
// One RV32I instruction word per line, byte address 0x00 upward in steps of 4
00000093
00a00113
00208463
00108093
ff9ff06f
00000013
00100193
00318233
00120213
fe419ee3
000002b3
00528313
0062c463
00000013
000300e7
0000006f
